// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_spdif_rx
FILELIST  := spdif_rx.f
LOG       := sim.log

SHELL       := /bin/bash
.SHELLFLAGS := -o pipefail -c

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@! grep -q "SOME TESTS FAILED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/spdif_pkg.sv
/* S/PDIF receiver constants, preamble codes, register map
   and the subframe and sample structs */
package spdif_pkg;

    localparam int clk_per_bit      = 4;
    localparam int half_cell_clks   = clk_per_bit / 2;
    localparam int subframe_clks    = 32 * clk_per_bit;
    // preamble spans slots 0 to 3
    localparam int preamble_clks    = 4 * clk_per_bit;
    localparam int data_slots       = 28;
    localparam int fifo_depth       = 8;
    localparam int cs_bits          = 32;
    localparam int frames_per_block = 192;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    localparam logic [apb_addr_w-1:0] reg_status = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_data   = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_cstat  = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_ctrl   = 8'h0C;

    // half-cell codes with the first half-cell high
    localparam logic [7:0] code_b = 8'b1110_1000;
    localparam logic [7:0] code_m = 8'b1110_0010;
    localparam logic [7:0] code_w = 8'b1110_0100;

    typedef enum logic [1:0] {
        pre_none,
        pre_b,
        pre_m,
        pre_w
    } preamble_t;

    typedef struct packed {
        preamble_t   preamble;
        logic [23:0] audio;
        logic        v;
        logic        u;
        logic        c;
        logic        parity_ok;
        logic [3:0]  aux;
    } subframe_t;

    typedef struct packed {
        logic        right;
        logic [23:0] audio;
    } sample_t;

endpackage

// File: hdl/spdif_apb_regs.sv
/* APB3 register block: status, sample data, channel status and control */
`timescale 1ns/1ps

module spdif_apb_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [spdif_pkg::apb_addr_w-1:0]       paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [spdif_pkg::apb_data_w-1:0]       pwdata,
    output logic [spdif_pkg::apb_data_w-1:0]       prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    input  logic                                   locked,
    input  logic                                   parity_err,
    input  logic                                   overflow,
    input  logic [$clog2(spdif_pkg::fifo_depth):0] fifo_count,
    input  logic                                   fifo_empty,
    input  spdif_pkg::sample_t                     fifo_head,
    output logic                                   fifo_pop,
    input  logic [spdif_pkg::cs_bits-1:0]          cstat,
    input  logic                                   cstat_valid,
    output logic                                   enable
);
    import spdif_pkg::*;

    localparam int cnt_w = $clog2(fifo_depth) + 1;

    logic               access;
    logic               rd_access;
    logic               wr_access;
    logic               mapped;
    logic               perr_flag;
    logic               ovf_flag;
    logic [cs_bits-1:0] cstat_q;

    assign access    = psel && penable;
    assign rd_access = access && !pwrite;
    assign wr_access = access && pwrite;
    assign pready    = 1'b1;
    assign pslverr   = access && !mapped;
    assign fifo_pop  = rd_access && paddr == reg_data && !fifo_empty;

    always_comb begin
        prdata = '0;
        mapped = 1'b1;
        case (paddr)
            reg_status: begin
                prdata[0]           = locked;
                prdata[1]           = perr_flag;
                prdata[2]           = ovf_flag;
                prdata[4 +: cnt_w]  = fifo_count;
            end
            reg_data: begin
                // empty reads as zero
                if (!fifo_empty) begin
                    prdata[$bits(sample_t)-1:0] = fifo_head;
                end
            end
            reg_cstat: prdata[cs_bits-1:0] = cstat_q;
            reg_ctrl:  prdata[0] = enable;
            default:   mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b1;
            perr_flag <= 1'b0;
            ovf_flag  <= 1'b0;
            cstat_q   <= '0;
        end else begin
            if (wr_access && paddr == reg_ctrl) begin
                enable <= pwdata[0];
                if (pwdata[1]) begin
                    perr_flag <= 1'b0;
                    ovf_flag  <= 1'b0;
                end
            end
            // a new event wins over a clear in the same cycle
            if (parity_err) begin
                perr_flag <= 1'b1;
            end
            if (overflow) begin
                ovf_flag <= 1'b1;
            end
            if (cstat_valid) begin
                cstat_q <= cstat;
            end
        end
    end

endmodule

// File: hdl/spdif_fifo.sv
/* synchronous FIFO with typed payload and overflow pulse */
`timescale 1ns/1ps

module spdif_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  payload_t               push_data,
    input  logic                   pop,
    output payload_t               pop_data,
    output logic [$clog2(depth):0] count,
    output logic                   empty,
    output logic                   overflow
);
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = ptr_w + 1;

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        next_ptr = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty    = count == '0;
    assign full     = count == cnt_w'(depth);
    assign do_pop   = pop && !empty;
    // a pop in the same cycle frees the slot
    assign do_push  = push && (!full || do_pop);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && !do_push;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop from empty FIFO");

endmodule

// File: hdl/spdif_rx_top.sv
/* S/PDIF receiver top: decoder, channel-status capture, sample FIFO, APB regs */
`timescale 1ns/1ps

module spdif_rx_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             spdif_in,
    input  logic [spdif_pkg::apb_addr_w-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [spdif_pkg::apb_data_w-1:0] pwdata,
    output logic [spdif_pkg::apb_data_w-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr
);
    import spdif_pkg::*;

    localparam int cnt_w = $clog2(fifo_depth) + 1;

    subframe_t          subframe;
    logic               subframe_valid;
    logic               locked;
    logic [cs_bits-1:0] cstat;
    logic               cstat_valid;
    logic               push;
    sample_t            push_data;
    logic               pop;
    sample_t            pop_data;
    logic [cnt_w-1:0]   count;
    logic               empty;
    logic               overflow;
    logic               enable;
    logic               parity_err;

    // good-parity subframes only, while enabled
    assign push       = subframe_valid && subframe.parity_ok && enable;
    assign push_data  = '{right: subframe.preamble == pre_w, audio: subframe.audio};
    assign parity_err = subframe_valid && !subframe.parity_ok;

    spdif_dai spdif_dai_inst (
        .clk            (clk),
        .rst            (rst),
        .spdif_in       (spdif_in),
        .subframe       (subframe),
        .subframe_valid (subframe_valid),
        .locked         (locked)
    );

    spdif_cs_capture spdif_cs_capture_inst (
        .clk            (clk),
        .rst            (rst),
        .subframe       (subframe),
        .subframe_valid (subframe_valid),
        .cstat          (cstat),
        .cstat_valid    (cstat_valid)
    );

    spdif_fifo #(
        .payload_t (sample_t),
        .depth     (fifo_depth)
    ) spdif_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .count     (count),
        .empty     (empty),
        .overflow  (overflow)
    );

    spdif_apb_regs spdif_apb_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .locked      (locked),
        .parity_err  (parity_err),
        .overflow    (overflow),
        .fifo_count  (count),
        .fifo_empty  (empty),
        .fifo_head   (pop_data),
        .fifo_pop    (pop),
        .cstat       (cstat),
        .cstat_valid (cstat_valid),
        .enable      (enable)
    );

endmodule

// File: sim/tb_spdif_rx.sv
/* testbench for the S/PDIF receiver: biphase-mark line model, APB tasks,
   directed tests, check task and watchdog */
`timescale 1ns/1ps

module tb_spdif_rx;
    import spdif_pkg::*;

    localparam int          frames_sent = 47;
    localparam int          limit_clks  = frames_sent * 256 + 4000;
    localparam int          poll_limit  = 64;
    localparam logic [31:0] cs_pattern  = 32'hC5A1_3E07;

    logic                  clk;
    logic                  rst;
    logic                  spdif_in;
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    logic [31:0] rng;
    logic        line_level;
    logic        relock;
    logic        sending;
    logic        slverr;
    logic [24:0] exp_q[$];
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    spdif_rx_top spdif_rx_top_inst (
        .clk      (clk),
        .rst      (rst),
        .spdif_in (spdif_in),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (limit_clks) @(posedge clk);
        $display("timeout: run did not finish within %0d clocks", limit_clks);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // IEC 60958 preamble codes, first half-cell high
    function automatic logic [7:0] preamble_code(input preamble_t kind);
        case (kind)
            pre_b:   return 8'b1110_1000;
            pre_m:   return 8'b1110_0010;
            default: return 8'b1110_0100;
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [31:0] data);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        slverr = pslverr;
        check("pready", 32'd1, 32'(pready));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [31:0] data);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // access phase, prdata settled mid-cycle
        @(negedge clk);
        data   = prdata;
        slverr = pslverr;
        check("pready", 32'd1, 32'(pready));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic drive_half(input logic level);
        spdif_in = level;
        repeat (half_cell_clks) @(posedge clk);
        #1;
    endtask

    // slots 4..27 audio lsb first, then v, u, c and even parity
    task automatic send_subframe(input preamble_t kind, input logic c,
                                 input logic bad_parity);
        logic [7:0]  code;
        logic [23:0] audio;
        logic [27:0] slots;
        rng       = xorshift(rng);
        audio     = rng[23:0];
        slots     = {1'b0, c, 1'b0, 1'b0, audio};
        slots[27] = ^slots[26:0] ^ bad_parity;
        code      = preamble_code(kind);
        if (line_level) begin
            code = ~code;
        end
        for (int i = 7; i >= 0; i--) begin
            drive_half(code[i]);
        end
        line_level = code[0];
        for (int i = 0; i < 28; i++) begin
            line_level = ~line_level;
            drive_half(line_level);
            if (slots[i]) begin
                line_level = ~line_level;
            end
            drive_half(line_level);
        end
        // first subframe of a burst only brings lock
        if (!relock && !bad_parity) begin
            exp_q.push_back({kind == pre_w, audio});
        end
        relock = 1'b0;
    endtask

    task automatic send_frame(input logic block_start, input logic c);
        send_subframe(block_start ? pre_b : pre_m, c, 1'b0);
        send_subframe(pre_w, c, 1'b0);
    endtask

    task automatic wait_count(input logic [3:0] want, output logic [31:0] st);
        int polls;
        polls = 0;
        apb_read(reg_status, st);
        while (st[7:4] != want && polls < poll_limit) begin
            apb_read(reg_status, st);
            polls++;
        end
        if (st[7:4] != want) begin
            $display("%s: FIFO count never reached %0d", test_name, want);
            errors++;
        end
    endtask

    task automatic wait_unlocked();
        logic [31:0] st;
        int          polls;
        polls = 0;
        apb_read(reg_status, st);
        while (st[0] && polls < poll_limit) begin
            apb_read(reg_status, st);
            polls++;
        end
        if (st[0]) begin
            $display("%s: decoder stayed locked on an idle line", test_name);
            errors++;
        end
    endtask

    task automatic start_burst();
        wait_unlocked();
        relock = 1'b1;
    endtask

    task automatic read_samples(input int n);
        logic [31:0] rd;
        logic [24:0] want;
        for (int i = 0; i < n; i++) begin
            apb_read(reg_data, rd);
            if (exp_q.size() == 0) begin
                $display("%s: more samples read than were sent", test_name);
                errors++;
            end else begin
                want = exp_q.pop_front();
                check("sample", 32'(want), rd);
            end
        end
    endtask

    task automatic drain_fifo();
        logic [31:0] st;
        logic [31:0] rd;
        int          polls;
        polls = 0;
        apb_read(reg_status, st);
        while (st[7:4] != 4'd0 && polls < poll_limit) begin
            apb_read(reg_data, rd);
            apb_read(reg_status, st);
            polls++;
        end
        if (st[7:4] != 4'd0) begin
            $display("%s: FIFO did not empty", test_name);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] rd;
        rst          = 1'b1;
        spdif_in     = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        rng          = 32'd19;
        line_level   = 1'b0;
        relock       = 1'b0;
        sending      = 1'b0;
        slverr       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset values");
        apb_read(reg_status, rd);
        check("status", 32'd0, rd);
        check("status slverr", 32'd0, 32'(slverr));
        apb_read(reg_ctrl, rd);
        check("ctrl", 32'd1, rd);
        apb_read(reg_data, rd);
        check("data", 32'd0, rd);
        // no register decodes at 0x10
        apb_read(8'h10, rd);
        check("unmapped slverr", 32'd1, 32'(slverr));
        end_test();

        begin_test("lock and capture");
        start_burst();
        for (int i = 0; i < 4; i++) begin
            send_frame(1'b0, 1'b0);
        end
        wait_count(4'd7, rd);
        check("locked", 32'd1, 32'(rd[0]));
        check("flags", 32'd0, 32'(rd[2:1]));
        read_samples(7);
        apb_read(reg_data, rd);
        check("empty data", 32'd0, rd);
        end_test();

        begin_test("channel status");
        start_burst();
        sending = 1'b1;
        fork
            begin
                send_frame(1'b0, 1'b0);
                for (int i = 0; i < cs_bits; i++) begin
                    send_frame(i == 0, cs_pattern[i]);
                end
                sending = 1'b0;
            end
            begin
                while (sending) begin
                    apb_read(reg_data, rd);
                end
            end
        join
        wait_unlocked();
        drain_fifo();
        exp_q.delete();
        apb_read(reg_cstat, rd);
        check("cstat", cs_pattern, rd);
        end_test();

        begin_test("parity error");
        start_burst();
        send_subframe(pre_m, 1'b0, 1'b0);
        send_subframe(pre_w, 1'b0, 1'b0);
        send_subframe(pre_m, 1'b0, 1'b1);
        send_subframe(pre_w, 1'b0, 1'b0);
        wait_unlocked();
        apb_read(reg_status, rd);
        check("count", 32'd2, 32'(rd[7:4]));
        check("parity flag", 32'd1, 32'(rd[1]));
        apb_write(reg_ctrl, 32'h3);
        apb_read(reg_status, rd);
        check("parity flag cleared", 32'd0, 32'(rd[1]));
        read_samples(2);
        end_test();

        begin_test("overflow");
        start_burst();
        for (int i = 0; i < 6; i++) begin
            send_frame(1'b0, 1'b0);
        end
        wait_unlocked();
        apb_read(reg_status, rd);
        check("count", 32'd8, 32'(rd[7:4]));
        check("overflow flag", 32'd1, 32'(rd[2]));
        read_samples(8);
        apb_read(reg_data, rd);
        check("empty data", 32'd0, rd);
        exp_q.delete();
        apb_write(reg_ctrl, 32'h3);
        end_test();

        begin_test("loss of lock");
        start_burst();
        send_frame(1'b0, 1'b0);
        send_frame(1'b0, 1'b0);
        apb_read(reg_status, rd);
        check("locked", 32'd1, 32'(rd[0]));
        repeat (300) @(posedge clk);
        #1;
        apb_read(reg_status, rd);
        check("unlocked", 32'd0, 32'(rd[0]));
        read_samples(3);
        end_test();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: spdif_dai/spdif_cs_capture.sv
/* channel-status capture from channel A, aligned to the B preamble */
`timescale 1ns/1ps

module spdif_cs_capture (
    input  logic                          clk,
    input  logic                          rst,
    input  spdif_pkg::subframe_t          subframe,
    input  logic                          subframe_valid,
    output logic [spdif_pkg::cs_bits-1:0] cstat,
    output logic                          cstat_valid
);
    import spdif_pkg::*;

    localparam int idx_w = $clog2(frames_per_block + 1);

    logic [idx_w-1:0]   frame_idx;
    logic               in_block;
    logic               chan_a;
    logic               is_b;
    logic               store_bit;
    logic               cs_last;
    logic [cs_bits-1:0] cs_sr;
    logic [cs_bits-1:0] cs_next;

    assign is_b   = subframe.preamble == pre_b;
    assign chan_a = subframe_valid && (is_b || subframe.preamble == pre_m);

    // frame_idx is the index of the channel-A frame now arriving
    assign store_bit = chan_a && (is_b || (in_block && frame_idx < idx_w'(cs_bits)));
    assign cs_last   = chan_a && !is_b && in_block && frame_idx == idx_w'(cs_bits - 1);
    assign cs_next   = {subframe.c, cs_sr[cs_bits-1:1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_idx   <= '0;
            in_block    <= 1'b0;
            cstat_valid <= 1'b0;
        end else begin
            cstat_valid <= cs_last;
            if (chan_a) begin
                if (is_b) begin
                    in_block  <= 1'b1;
                    frame_idx <= idx_w'(1);
                end else if (in_block) begin
                    // block ran past its length with no new B
                    if (frame_idx == idx_w'(frames_per_block)) begin
                        in_block <= 1'b0;
                    end else begin
                        frame_idx <= frame_idx + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_bit) begin
            cs_sr <= cs_next;
        end
        if (cs_last) begin
            cstat <= cs_next;
        end
    end

endmodule

// File: spdif_dai/spdif_dai.sv
/* S/PDIF biphase-mark decoder: input synchronizer, preamble search
   and lock, data slot decode and even parity check */
`timescale 1ns/1ps

module spdif_dai (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 spdif_in,
    output spdif_pkg::subframe_t subframe,
    output logic                 subframe_valid,
    output logic                 locked
);
    import spdif_pkg::*;

    localparam int hist_len = preamble_clks - 1;
    localparam int phase_w  = $clog2(subframe_clks) + 1;
    localparam int run_clks = 3 * half_cell_clks;

    localparam logic [phase_w-1:0] pre_end  = phase_w'(preamble_clks - 1);
    localparam logic [phase_w-1:0] last_clk = phase_w'(subframe_clks - 1);
    localparam logic [phase_w-1:0] bit_mask = phase_w'(clk_per_bit - 1);

    typedef enum logic [1:0] {
        st_search,
        st_check,
        st_locked
    } state_t;

    state_t                 state;
    logic                   sync1;
    logic [hist_len-1:0]    hist;
    logic [phase_w-1:0]     phase;
    logic [7:0]             code;
    preamble_t              code_type;
    preamble_t              pre_q;
    logic                   run_start;
    logic                   armed;
    logic                   bit_strobe;
    logic                   data_bit;
    logic                   last_slot;
    logic [data_slots-1:0]  data_sr;
    logic [data_slots-1:0]  data_next;

    function automatic preamble_t classify(input logic [7:0] hc);
        logic [7:0] norm;
        norm = hc[7] ? hc : ~hc;
        case (norm)
            code_b:  classify = pre_b;
            code_m:  classify = pre_m;
            code_w:  classify = pre_w;
            default: classify = pre_none;
        endcase
    endfunction

    // hist[0] is the newest synchronized sample
    always_ff @(posedge clk) begin
        if (rst) begin
            sync1 <= 1'b0;
            hist  <= '0;
        end else begin
            sync1 <= spdif_in;
            hist  <= {hist[hist_len-2:0], sync1};
        end
    end

    // second sample of each of the eight preamble half-cells
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            code[i] = hist[2*i];
        end
    end

    assign code_type = classify(code);

    // a transition followed by three half-cells at one level
    assign run_start = (hist[run_clks] != hist[0]) &&
                       ((&hist[run_clks-1:0]) || !(|hist[run_clks-1:0]));

    // a one has a transition between its two half-cells
    assign bit_strobe = (phase > pre_end) && ((phase & bit_mask) == bit_mask);
    assign data_bit   = hist[0] != hist[half_cell_clks];
    assign data_next  = {data_bit, data_sr[data_slots-1:1]};
    assign last_slot  = phase == last_clk;
    assign locked     = state == st_locked;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= st_search;
            phase          <= '0;
            armed          <= 1'b0;
            subframe_valid <= 1'b0;
        end else begin
            subframe_valid <= 1'b0;
            case (state)
                st_search: begin
                    phase <= '0;
                    if (run_start) begin
                        // hist[0] already holds the sixth preamble sample
                        phase <= phase_w'(run_clks);
                        state <= st_check;
                    end
                end
                st_check, st_locked: begin
                    phase <= last_slot ? '0 : phase + 1'b1;
                    if (phase == pre_end) begin
                        if (code_type == pre_none) begin
                            state <= st_search;
                            armed <= 1'b0;
                        end else begin
                            // only subframes whose boundary was predicted go out
                            armed <= state == st_locked;
                            state <= st_locked;
                        end
                    end
                    if (last_slot) begin
                        subframe_valid <= armed;
                    end
                end
                default: state <= st_search;
            endcase
        end
    end

    // slots arrive lsb first
    always_ff @(posedge clk) begin
        if (bit_strobe) begin
            data_sr <= data_next;
        end
        if (phase == pre_end) begin
            pre_q <= code_type;
        end
        if (last_slot) begin
            subframe <= '{preamble:  pre_q,
                          audio:     data_next[23:0],
                          v:         data_next[24],
                          u:         data_next[25],
                          c:         data_next[26],
                          parity_ok: ~^data_next,
                          aux:       data_next[3:0]};
        end
    end

    assert property (@(posedge clk) disable iff (rst) subframe_valid |-> locked)
        else $error("subframe_valid while not locked");

    assert property (@(posedge clk) disable iff (rst) phase < phase_w'(subframe_clks))
        else $error("phase counter out of range");

endmodule

// File: spdif_rx.f
common/spdif_pkg.sv
spdif_dai/spdif_dai.sv
spdif_dai/spdif_cs_capture.sv
hdl/spdif_fifo.sv
hdl/spdif_apb_regs.sv
hdl/spdif_rx_top.sv
sim/tb_spdif_rx.sv
